/* include/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath width of the integer pipeline.
`define DATA_WIDTH 32

// register file has 32 entries.
`define REG_IDX_WIDTH 5

// iterations of the shift-add multiplier.
// Any count of at least 32 works, later steps only shift in zeros.
`define MUL_STEPS 32

`endif

/* rtl/exePkg.sv */
package exePkg;

    // ALU opcodes as passed down by decode.
    typedef enum logic [4:0] {
        opNop,
        opAdd,      // traps on signed overflow.
        opAddu,
        opSub,      // traps on signed overflow.
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opLui,
        opClo,
        opClz,
        opMul,
        opMemAddr   // rs plus sign-extended imm16.
    } aluOp_t;

    typedef enum logic [1:0] {
        mulIdle,
        mulRun,
        mulDone
    } mulState_t;

endpackage

/* rtl/executeStage.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module executeStage
    import exePkg::*;
    import memPkg::*;
(
    input  logic                      Clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      dmStall,
    input  logic                      dValid,
    input  logic [`DATA_WIDTH-1:0]    dPc,
    input  aluOp_t                    dOp,
    input  memKind_t                  dMemKind,
    input  logic [`REG_IDX_WIDTH-1:0] dRsIdx,
    input  logic [`REG_IDX_WIDTH-1:0] dRtIdx,
    input  logic [`DATA_WIDTH-1:0]    dRsData,
    input  logic [`DATA_WIDTH-1:0]    dRtData,
    input  logic [4:0]                dShamt,
    input  logic [15:0]               dImm16,
    input  logic                      dRegWrite,
    input  logic [`REG_IDX_WIDTH-1:0] dRegIdx,
    input  logic                      mRegWrite,
    input  logic                      mIsLoad,
    input  logic [`REG_IDX_WIDTH-1:0] mRegIdx,
    input  logic [`DATA_WIDTH-1:0]    mData,
    output logic                      busy,
    output logic                      eValid,
    output logic [`DATA_WIDTH-1:0]    ePc,
    output logic                      eRegWrite,
    output logic [`REG_IDX_WIDTH-1:0] eRegIdx,
    output logic [`DATA_WIDTH-1:0]    eData,
    output logic [`DATA_WIDTH-1:0]    eWriteMemData,
    output memKind_t                  eMemKind,
    output logic [3:0]                eByteEn,
    output logic                      eMemRead,
    output logic                      eOverflow,
    output logic                      eUnaligned
);

    logic [`DATA_WIDTH-1:0] rsVal, rtVal, aluResult, product;
    logic                   aluOverflow, memRead, unaligned, fault;
    logic [3:0]             byteEn;
    logic                   mulBusy, mulDone, mulStart, acceptAlu;
    logic                   sideValid, sideHasProd; // side register occupied / product ready.
    logic [`DATA_WIDTH-1:0] sidePc, sideWriteMemData, sideProduct;
    logic                   sideRegWrite;
    logic [`REG_IDX_WIDTH-1:0] sideRegIdx;

    forwardUnit forwardUnit_inst (
        .rsIdx(dRsIdx), .rtIdx(dRtIdx), .rsData(dRsData), .rtData(dRtData),
        .eValid(eValid), .eRegWrite(eRegWrite), .eIsLoad(eMemRead),
        .eRegIdx(eRegIdx), .eData(eData),
        .mRegWrite(mRegWrite), .mIsLoad(mIsLoad), .mRegIdx(mRegIdx), .mData(mData),
        .rsVal(rsVal), .rtVal(rtVal)
    );

    intAlu intAlu_inst (
        .op(dOp), .a(rsVal), .b(rtVal), .shamt(dShamt), .imm16(dImm16),
        .result(aluResult), .overflow(aluOverflow)
    );

    iterMultiplier iterMultiplier_inst (
        .Clk(Clk), .rst(rst), .abort(flush), .start(mulStart), .a(rsVal), .b(rtVal),
        .product(product), .busy(mulBusy), .done(mulDone)
    );

    lsuAddrGen lsuAddrGen_inst (
        .kind(dMemKind), .addr(aluResult), .byteEn(byteEn),
        .memRead(memRead), .unaligned(unaligned)
    );

    assign busy      = mulBusy | sideValid;
    assign mulStart  = dValid && (dOp == opMul) && !busy;
    assign acceptAlu = dValid && (dOp != opMul) && !busy && !dmStall;
    assign fault     = aluOverflow | unaligned; // a faulting instruction writes nothing.

    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            sideValid   <= 1'b0;
            sideHasProd <= 1'b0;
        end else if (mulStart) begin
            sideValid <= 1'b1;
        end else if (mulDone) begin
            sideHasProd <= 1'b1;
        end else if (sideHasProd && !dmStall) begin
            sideValid   <= 1'b0; // product moves into the E register on this edge.
            sideHasProd <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (mulStart) begin
            sidePc           <= dPc;
            sideRegWrite     <= dRegWrite;
            sideRegIdx       <= dRegIdx;
            sideWriteMemData <= rtVal;
        end
        if (mulDone)
            sideProduct <= product;
    end

    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            eValid     <= 1'b0;
            eRegWrite  <= 1'b0;
            eByteEn    <= 4'b0000;
            eMemRead   <= 1'b0;
            eOverflow  <= 1'b0;
            eUnaligned <= 1'b0;
            if (rst)
                ePc <= '0;
        end else if (!dmStall) begin
            if (sideHasProd) begin
                eValid        <= 1'b1;
                ePc           <= sidePc;
                eRegWrite     <= sideRegWrite;
                eRegIdx       <= sideRegIdx;
                eData         <= sideProduct;
                eWriteMemData <= sideWriteMemData;
                eMemKind      <= memNone;
                eByteEn       <= 4'b0000;
                eMemRead      <= 1'b0;
                eOverflow     <= 1'b0;
                eUnaligned    <= 1'b0;
            end else if (acceptAlu) begin
                eValid        <= 1'b1;
                ePc           <= dPc;
                eRegWrite     <= dRegWrite && !fault;
                eRegIdx       <= dRegIdx;
                eData         <= aluResult;
                eWriteMemData <= rtVal;
                eMemKind      <= dMemKind;
                eByteEn       <= byteEn & {4{!fault}};
                eMemRead      <= memRead;
                eOverflow     <= aluOverflow;
                eUnaligned    <= unaligned;
            end else begin
                eValid    <= 1'b0; // bubble.
                eRegWrite <= 1'b0;
                eByteEn   <= 4'b0000;
                eMemRead  <= 1'b0;
            end
        end
    end

endmodule

/* rtl/forwardUnit.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module forwardUnit (
    input  logic [`REG_IDX_WIDTH-1:0] rsIdx,
    input  logic [`REG_IDX_WIDTH-1:0] rtIdx,
    input  logic [`DATA_WIDTH-1:0]    rsData,
    input  logic [`DATA_WIDTH-1:0]    rtData,
    input  logic                      eValid,
    input  logic                      eRegWrite,
    input  logic                      eIsLoad,
    input  logic [`REG_IDX_WIDTH-1:0] eRegIdx,
    input  logic [`DATA_WIDTH-1:0]    eData,
    input  logic                      mRegWrite,
    input  logic                      mIsLoad,
    input  logic [`REG_IDX_WIDTH-1:0] mRegIdx,
    input  logic [`DATA_WIDTH-1:0]    mData,
    output logic [`DATA_WIDTH-1:0]    rsVal,
    output logic [`DATA_WIDTH-1:0]    rtVal
);

    // the nearer E stage wins over M. Load data is not known yet in either stage.
    function automatic logic [`DATA_WIDTH-1:0] pickOperand(
        input logic [`REG_IDX_WIDTH-1:0] idx,
        input logic [`DATA_WIDTH-1:0]    rfData
    );
        if (idx == '0)
            return '0;
        else if (eValid && eRegWrite && !eIsLoad && eRegIdx == idx)
            return eData;
        else if (mRegWrite && !mIsLoad && mRegIdx == idx)
            return mData;
        else
            return rfData;
    endfunction

    always_comb begin
        rsVal = pickOperand(rsIdx, rsData);
        rtVal = pickOperand(rtIdx, rtData);
    end

endmodule

/* rtl/intAlu.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module intAlu
    import exePkg::*;
(
    input  aluOp_t                 op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  logic [4:0]             shamt,
    input  logic [15:0]            imm16,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   overflow
);

    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] diff;
    logic [`DATA_WIDTH-1:0] immExt;

    // number of zero bits above the highest set bit.
    function automatic logic [5:0] leadZeros(input logic [`DATA_WIDTH-1:0] v);
        logic [5:0] n;
        logic       seen;
        n    = '0;
        seen = 1'b0;
        for (int i = `DATA_WIDTH - 1; i >= 0; i--) begin
            if (!seen) begin
                if (v[i])
                    seen = 1'b1;
                else
                    n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign sum    = a + b;
    assign diff   = a - b;
    assign immExt = {{(`DATA_WIDTH - 16){imm16[15]}}, imm16};

    always_comb begin
        result = '0;
        case (op)
            opAdd, opAddu: result = sum;
            opSub, opSubu: result = diff;
            opAnd:         result = a & b;
            opOr:          result = a | b;
            opXor:         result = a ^ b;
            opNor:         result = ~(a | b);
            opSlt:         result = {{(`DATA_WIDTH - 1){1'b0}}, $signed(a) < $signed(b)};
            opSltu:        result = {{(`DATA_WIDTH - 1){1'b0}}, a < b};
            opSll:         result = b << shamt;
            opSrl:         result = b >> shamt;
            opSra:         result = $signed(b) >>> shamt;
            opLui:         result = {imm16, 16'b0};
            opClo:         result = {{(`DATA_WIDTH - 6){1'b0}}, leadZeros(~a)};
            opClz:         result = {{(`DATA_WIDTH - 6){1'b0}}, leadZeros(a)};
            opMemAddr:     result = a + immExt;
            default:       result = '0; // nop, and mul which has its own unit.
        endcase
    end

    // signed overflow when both inputs agree in sign and the result does not.
    always_comb begin
        overflow = 1'b0;
        if (op == opAdd)
            overflow = (a[31] == b[31]) && (sum[31] != a[31]);
        else if (op == opSub)
            overflow = (a[31] != b[31]) && (diff[31] != a[31]);
    end

endmodule

/* rtl/iterMultiplier.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module iterMultiplier
    import exePkg::*;
(
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   abort,
    input  logic                   start,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] product,
    output logic                   busy,
    output logic                   done
);

    localparam int CNT_W = $clog2(`MUL_STEPS + 1);

    mulState_t              state;
    logic [CNT_W-1:0]       stepCnt;
    logic [`DATA_WIDTH-1:0] mcand;
    logic [`DATA_WIDTH-1:0] mplier;
    logic [`DATA_WIDTH-1:0] acc;

    always_ff @(posedge Clk) begin
        if (rst || abort) begin
            state   <= mulIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                mulIdle: begin
                    if (start) begin
                        state   <= mulRun;
                        stepCnt <= '0;
                    end
                end
                mulRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == CNT_W'(`MUL_STEPS - 1))
                        state <= mulDone; // last partial product goes in on this edge.
                end
                mulDone: state <= mulIdle;
                default: state <= mulIdle;
            endcase
        end
    end

    // one multiplier bit per step; only the low word of the product is kept.
    always_ff @(posedge Clk) begin
        if (state == mulIdle && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == mulRun) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;
    assign busy    = (state != mulIdle);
    assign done    = (state == mulDone);

endmodule

/* rtl/lsuAddrGen.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module lsuAddrGen
    import memPkg::*;
(
    input  memKind_t               kind,
    input  logic [`DATA_WIDTH-1:0] addr,
    output logic [3:0]             byteEn,
    output logic                   memRead,
    output logic                   unaligned
);

    logic [1:0] offset;

    assign offset = addr[1:0];

    always_comb begin
        unaligned = 1'b0;
        case (kind)
            memLh, memLhu, memSh: unaligned = offset[0];
            memLw, memSw:         unaligned = (offset != 2'b00);
            default:              unaligned = 1'b0;
        endcase
    end

    // lanes are little endian, byte 0 sits in bit 0 of the enable.
    always_comb begin
        byteEn = 4'b0000;
        if (!unaligned) begin
            case (kind)
                memSw:   byteEn = 4'b1111;
                memSh:   byteEn = 4'b0011 << offset;
                memSb:   byteEn = 4'b0001 << offset;
                default: byteEn = 4'b0000;
            endcase
        end
    end

    assign memRead = (kind == memLb) || (kind == memLbu) || (kind == memLh) ||
                     (kind == memLhu) || (kind == memLw);

endmodule

/* rtl/memPkg.sv */
package memPkg;

    // kind of data memory access carried by an instruction.
    typedef enum logic [3:0] {
        memNone,
        memLb,
        memLbu,
        memLh,
        memLhu,
        memLw,
        memSb,
        memSh,
        memSw
    } memKind_t;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tbExecuteStage -f sources.f \
    -o simExecuteStage
./obj_dir/simExecuteStage

/* sources.f */
+incdir+include
rtl/exePkg.sv
rtl/memPkg.sv
rtl/forwardUnit.sv
rtl/intAlu.sv
rtl/iterMultiplier.sv
rtl/lsuAddrGen.sv
rtl/executeStage.sv
verif/tbExecuteStage.sv

/* verif/exeGolden.txt */
# op mem rsIdx rtIdx rsData rtData shamt imm16 regWrite regIdx mRegWrite mIsLoad mRegIdx mData
# stallCycles flush | expected eData eByteEn eMemRead eOverflow eUnaligned (all hex)
01 0 01 02 00000005 00000007 00 0000 1 0a 0 0 00 00000000 00 0 0000000c 0 0 0 0
02 0 03 04 ffffffff 00000002 00 0000 1 0b 0 0 00 00000000 00 0 00000001 0 0 0 0
01 0 03 04 7fffffff 00000001 00 0000 1 0c 0 0 00 00000000 00 0 80000000 0 0 1 0
03 0 05 06 80000000 00000001 00 0000 1 0d 0 0 00 00000000 00 0 7fffffff 0 0 1 0
04 0 05 06 00000003 00000005 00 0000 1 0e 0 0 00 00000000 00 0 fffffffe 0 0 0 0
05 0 01 02 f0f0ff00 0ff00ff0 00 0000 1 0f 0 0 00 00000000 00 0 00f00f00 0 0 0 0
06 0 01 02 12340000 00005678 00 0000 1 10 0 0 00 00000000 00 0 12345678 0 0 0 0
07 0 01 02 ffff0000 0f0f0f0f 00 0000 1 11 0 0 00 00000000 00 0 f0f00f0f 0 0 0 0
08 0 01 02 00ff00ff 0f000000 00 0000 1 12 0 0 00 00000000 00 0 f000ff00 0 0 0 0
09 0 01 02 ffffffff 00000001 00 0000 1 13 0 0 00 00000000 00 0 00000001 0 0 0 0
0a 0 01 02 ffffffff 00000001 00 0000 1 14 0 0 00 00000000 00 0 00000000 0 0 0 0
0b 0 00 02 ffffffff 00000081 04 0000 1 15 0 0 00 00000000 00 0 00000810 0 0 0 0
0c 0 00 02 00000000 80000000 1f 0000 1 16 0 0 00 00000000 00 0 00000001 0 0 0 0
0d 0 00 02 00000000 80000010 04 0000 1 17 0 0 00 00000000 00 0 f8000001 0 0 0 0
0e 0 00 00 00000000 00000000 00 1234 1 18 0 0 00 00000000 00 0 12340000 0 0 0 0
0f 0 01 00 fff00000 00000000 00 0000 1 19 0 0 00 00000000 00 0 0000000c 0 0 0 0
10 0 01 00 00010000 00000000 00 0000 1 1a 0 0 00 00000000 00 0 0000000f 0 0 0 0
10 0 01 00 00000000 00000000 00 0000 1 1b 0 0 00 00000000 00 0 00000020 0 0 0 0
02 0 01 02 00000100 00000023 00 0000 1 05 0 0 00 00000000 00 0 00000123 0 0 0 0
02 0 05 02 deadbeef 00000001 00 0000 1 06 1 0 05 0000aaaa 00 0 00000124 0 0 0 0
02 0 07 08 11111111 00000010 00 0000 1 09 1 0 07 00000500 00 0 00000510 0 0 0 0
02 0 07 00 00000020 ffffffff 00 0000 1 0a 1 1 07 00000500 00 0 00000020 0 0 0 0
02 0 01 02 00000001 00000001 00 0000 1 00 0 0 00 00000000 00 0 00000002 0 0 0 0
06 0 00 03 ffffffff 00000004 00 0000 1 0b 1 0 00 12345678 00 0 00000004 0 0 0 0
11 0 01 02 00012345 00006789 00 0000 1 0c 0 0 00 00000000 00 0 75cca2ed 0 0 0 0
02 0 0c 02 00000000 00000013 00 0000 1 0d 0 0 00 00000000 00 0 75cca300 0 0 0 0
11 0 01 02 ffffffff 00000003 00 0000 1 0e 0 0 00 00000000 00 0 fffffffd 0 0 0 0
12 1 01 00 00001000 00000000 00 0003 1 14 0 0 00 00000000 00 0 00001003 0 1 0 0
12 2 01 00 00001000 00000000 00 ffff 1 15 0 0 00 00000000 00 0 00000fff 0 1 0 0
12 3 01 00 00002000 00000000 00 0002 1 16 0 0 00 00000000 00 0 00002002 0 1 0 0
12 3 01 00 00002000 00000000 00 0001 1 17 0 0 00 00000000 00 0 00002001 0 1 0 1
12 4 01 00 00002000 00000000 00 0003 1 18 0 0 00 00000000 00 0 00002003 0 1 0 1
12 5 01 00 00003000 00000000 00 0004 1 19 0 0 00 00000000 00 0 00003004 0 1 0 0
12 5 01 00 00003000 00000000 00 0002 1 1a 0 0 00 00000000 00 0 00003002 0 1 0 1
12 5 01 00 00003000 00000000 00 0001 1 1b 0 0 00 00000000 00 0 00003001 0 1 0 1
12 6 01 02 00004000 000000aa 00 0000 0 00 0 0 00 00000000 00 0 00004000 1 0 0 0
12 6 01 02 00004000 000000aa 00 0001 0 00 0 0 00 00000000 00 0 00004001 2 0 0 0
12 6 01 02 00004000 000000aa 00 0002 0 00 0 0 00 00000000 00 0 00004002 4 0 0 0
12 6 01 02 00004000 000000aa 00 0003 0 00 0 0 00 00000000 00 0 00004003 8 0 0 0
12 7 01 02 00004000 000000aa 00 0000 0 00 0 0 00 00000000 00 0 00004000 3 0 0 0
12 7 01 02 00004000 000000aa 00 0002 0 00 0 0 00 00000000 00 0 00004002 c 0 0 0
12 7 01 02 00004000 000000aa 00 0001 0 00 0 0 00 00000000 00 0 00004001 0 0 0 1
12 7 01 02 00004000 000000aa 00 0003 0 00 0 0 00 00000000 00 0 00004003 0 0 0 1
12 8 01 02 00004000 000000aa 00 0000 0 00 0 0 00 00000000 00 0 00004000 f 0 0 0
12 8 01 02 00004000 000000aa 00 0001 0 00 0 0 00 00000000 00 0 00004001 0 0 0 1
12 8 01 02 00004000 000000aa 00 0002 0 00 0 0 00 00000000 00 0 00004002 0 0 0 1
12 8 01 02 00004000 000000aa 00 0003 0 00 0 0 00 00000000 00 0 00004003 0 0 0 1
02 0 01 02 00000010 00000020 00 0000 1 1c 0 0 00 00000000 03 0 00000030 0 0 0 0
11 0 01 02 00000007 00000006 00 0000 1 1d 0 0 00 00000000 28 0 0000002a 0 0 0 0
02 0 01 02 00000001 00000002 00 0000 1 1e 0 0 00 00000000 00 1 00000003 0 0 0 0
11 0 01 02 00000009 00000009 00 0000 1 1f 0 0 00 00000000 00 1 00000000 0 0 0 0
02 0 03 04 00000002 00000003 00 0000 1 01 0 0 00 00000000 00 0 00000005 0 0 0 0

/* verif/tbExecuteStage.sv */
`timescale 1ns/100ps
`include "exe_macros.svh"

module tbExecuteStage
    import exePkg::*;
    import memPkg::*;
();

    logic                      Clk, rst, flush, dmStall, dValid;
    logic [`DATA_WIDTH-1:0]    dPc, dRsData, dRtData, mData;
    aluOp_t                    dOp;
    memKind_t                  dMemKind;
    logic [`REG_IDX_WIDTH-1:0] dRsIdx, dRtIdx, dRegIdx, mRegIdx;
    logic [4:0]                dShamt;
    logic [15:0]               dImm16;
    logic                      dRegWrite, mRegWrite, mIsLoad;
    logic                      busy, eValid, eRegWrite, eMemRead, eOverflow, eUnaligned;
    logic [`DATA_WIDTH-1:0]    ePc, eData, eWriteMemData;
    logic [`REG_IDX_WIDTH-1:0] eRegIdx;
    memKind_t                  eMemKind;
    logic [3:0]                eByteEn;

    int           fd;
    int           lineCount;
    int           lineNo;
    bit           loaded;
    string        textLine;
    logic [113:0] heldE; // every E output, captured when a stall starts.

    bit                        eForwards; // the E register holds a result that forwards.
    logic [`REG_IDX_WIDTH-1:0] eFwdIdx;
    logic [`DATA_WIDTH-1:0]    eFwdData;

    executeStage executeStage_inst (.*);

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    task automatic stopRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "execute stage test stopped at the first error");
    endtask

    task automatic checkData(input string name, input logic [`DATA_WIDTH-1:0] exp,
                             input logic [`DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkIdx(input string name, input logic [`REG_IDX_WIDTH-1:0] exp,
                            input logic [`REG_IDX_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkByteEn(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkKind(input string name, input memKind_t exp, input memKind_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(),
                     act.name());
            stopRun();
        end
    endtask

    task automatic checkHeld(input logic [113:0] exp, input logic [113:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: E register expected %h, got %h", $time, exp, act);
            stopRun();
        end
    endtask

    function automatic logic [113:0] snapshotE();
        return {eValid, ePc, eRegWrite, eRegIdx, eData, eWriteMemData, eMemKind, eByteEn,
                eMemRead, eOverflow, eUnaligned};
    endfunction

    // lines starting with # describe the columns.
    function automatic bit isDataLine(input string s);
        return s.len() > 1 && s.getc(0) != "#";
    endfunction

    task automatic openGolden();
        fd = $fopen("verif/exeGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file verif/exeGolden.txt");
            stopRun();
        end
    endtask

    task automatic countLines();
        string s;
        openGolden();
        lineCount = 0;
        while ($fgets(s, fd) > 0) begin
            if (isDataLine(s))
                lineCount++;
        end
        $fclose(fd);
    endtask

    task automatic runLine(input string s);
        logic [31:0]            f [21];
        logic                   isMul;
        logic                   expRegWrite;
        logic [`DATA_WIDTH-1:0] expRt;
        int                     n;
        n = $sscanf(s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
        if (n != 21) begin
            $display("golden line %0d has %0d fields instead of 21", lineNo, n);
            stopRun();
        end
        dOp       = aluOp_t'(f[0][4:0]);
        dMemKind  = memKind_t'(f[1][3:0]);
        dRsIdx    = f[2][4:0];
        dRtIdx    = f[3][4:0];
        dRsData   = f[4];
        dRtData   = f[5];
        dShamt    = f[6][4:0];
        dImm16    = f[7][15:0];
        dRegWrite = f[8][0];
        dRegIdx   = f[9][4:0];
        mRegWrite = f[10][0];
        mIsLoad   = f[11][0];
        mRegIdx   = f[12][4:0];
        mData     = f[13];
        dPc       = 32'h0040_0000 + 32'(lineNo) * 4;
        dValid    = 1'b1;
        isMul     = (dOp == opMul);
        expRegWrite = dRegWrite && !f[19][0] && !f[20][0]; // a fault writes nothing.

        // store data is the rt operand under the forwarding rule.
        if (dRtIdx == '0)
            expRt = '0;
        else if (eForwards && eFwdIdx == dRtIdx)
            expRt = eFwdData;
        else if (mRegWrite && !mIsLoad && mRegIdx == dRtIdx)
            expRt = mData;
        else
            expRt = dRtData;

        if (f[14] != 0) begin
            dmStall = 1'b1;
            heldE   = snapshotE();
            repeat (f[14]) begin
                @(negedge Clk);
                if (isMul && busy)
                    dValid = 1'b0; // a mul is taken even while stalled.
                checkHeld(heldE, snapshotE());
            end
            dmStall = 1'b0;
        end

        if (isMul && f[15][0]) begin
            @(negedge Clk);
            checkFlag("busy", 1'b1, busy);
            dValid = 1'b0;
            repeat (4) @(negedge Clk);
            flush = 1'b1;
            @(negedge Clk);
            flush = 1'b0;
            checkFlag("busy", 1'b0, busy);
            repeat (`MUL_STEPS + 4) begin
                @(negedge Clk);
                checkFlag("eValid", 1'b0, eValid); // the aborted product must never arrive.
            end
            eForwards = 1'b0;
        end else begin
            do begin
                @(negedge Clk);
                if (isMul && !eValid) begin
                    checkFlag("busy", 1'b1, busy);
                    dValid = 1'b0;
                end
            end while (!eValid);
            dValid = 1'b0;
            checkFlag("busy", 1'b0, busy);
            checkData("eData", f[16], eData);
            checkData("ePc", dPc, ePc);
            checkByteEn("eByteEn", f[17][3:0], eByteEn);
            checkFlag("eMemRead", f[18][0], eMemRead);
            checkFlag("eOverflow", f[19][0], eOverflow);
            checkFlag("eUnaligned", f[20][0], eUnaligned);
            checkFlag("eRegWrite", expRegWrite, eRegWrite);
            checkKind("eMemKind", isMul ? memNone : dMemKind, eMemKind);
            checkIdx("eRegIdx", dRegIdx, eRegIdx);
            checkData("eWriteMemData", expRt, eWriteMemData);
            eForwards = expRegWrite && !f[18][0];
            eFwdIdx   = dRegIdx;
            eFwdData  = f[16];
            if (f[15][0]) begin
                dmStall = 1'b1; // the stall alone would keep this result in the E register.
                flush   = 1'b1;
                @(negedge Clk);
                flush   = 1'b0;
                dmStall = 1'b0;
                checkFlag("eValid", 1'b0, eValid);
                checkFlag("eRegWrite", 1'b0, eRegWrite);
                checkByteEn("eByteEn", 4'b0000, eByteEn);
                eForwards = 1'b0;
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        dmStall   = 1'b0;
        dValid    = 1'b0;
        dPc       = '0;
        dOp       = opNop;
        dMemKind  = memNone;
        dRsIdx    = '0;
        dRtIdx    = '0;
        dRsData   = '0;
        dRtData   = '0;
        dShamt    = '0;
        dImm16    = '0;
        dRegWrite = 1'b0;
        dRegIdx   = '0;
        mRegWrite = 1'b0;
        mIsLoad   = 1'b0;
        mRegIdx   = '0;
        mData     = '0;
        countLines();
        loaded = 1'b1;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        checkFlag("busy", 1'b0, busy);
        checkFlag("eValid", 1'b0, eValid);
        checkFlag("eRegWrite", 1'b0, eRegWrite);
        checkFlag("eMemRead", 1'b0, eMemRead);
        checkFlag("eOverflow", 1'b0, eOverflow);
        checkFlag("eUnaligned", 1'b0, eUnaligned);
        checkByteEn("eByteEn", 4'b0000, eByteEn);
        checkData("ePc", '0, ePc);
        openGolden();
        lineNo = 0;
        while ($fgets(textLine, fd) > 0) begin
            if (isDataLine(textLine)) begin
                runLine(textLine);
                lineNo++;
            end
        end
        $fclose(fd);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // a mul line is the longest case, a little over MUL_STEPS cycles.
    initial begin
        wait (loaded);
        repeat (lineCount * (`MUL_STEPS + 10) + 10) @(posedge Clk);
        $display("timeout: the golden lines did not finish in the allowed number of cycles");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
